// File: logic/beq_4_pkg.sv
package beq_4_pkg;

    // data words and addresses share one width
    typedef logic [31:0] word_t;

    // register number as found in the rs, rt and rd fields
    typedef logic [4:0] reg_idx_t;

    // instruction fields used by the decoder
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // opcodes this core understands
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2B;
    localparam opcode_t OP_BEQ     = 6'h04;

    // function code of jr under OP_SPECIAL
    localparam funct_t FUNCT_JR = 6'h08;

    // first fetch address after reset
    localparam word_t RESET_VECTOR = 32'hBFC00000;

    // instruction memory depth in words
    localparam int IRAM_WORDS = 4096;

    // fetch keeps running until jr r0 has had its delay slot fetched
    typedef enum logic {
        RUNNING,
        HALTED
    } run_state_t;

    // fetch to decode pipeline register
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_decode_t;

    // decode to execute pipeline register, only memory ops are valid here
    typedef struct packed {
        logic     valid;
        logic     is_load;
        logic     is_store;
        reg_idx_t dest;
        word_t    base;
        word_t    offset;
        word_t    store_data;
    } decode_execute_t;

    // register write from execute
    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
    } reg_write_t;

    // branch or jr resolved in decode
    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_redirect_t;

endpackage

// File: logic/beq_4_iram.sv
module beq_4_iram (
    input  beq_4_pkg::word_t instr_address,
    output beq_4_pkg::word_t instr_readdata
);

    import beq_4_pkg::*;

    word_t instr_ram [0:IRAM_WORDS-1];

    // byte offset from the reset vector, then the word index
    word_t byte_offset;
    word_t word_index;

    assign byte_offset = instr_address % RESET_VECTOR;
    assign word_index  = byte_offset >> 2;

    // i-type encoding helper
    function automatic word_t i_type(opcode_t op, reg_idx_t rs, reg_idx_t rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    initial begin
        int w;
        int i;

        // unused words read back as nop
        for (w = 0; w < IRAM_WORDS; w++) begin
            instr_ram[w] = '0;
        end

        w = 0;

        // lw ri, 4*(i-2)(r0) for r2 to r31
        for (i = 2; i <= 31; i++) begin
            instr_ram[w] = i_type(OP_LW, 5'd0, reg_idx_t'(i), 16'((i - 2) * 4));
            w++;
        end

        // one group per neighbouring register pair
        for (i = 2; i <= 30; i++) begin
            // equal pair skips the zero store
            instr_ram[w] = i_type(OP_BEQ, reg_idx_t'(i), reg_idx_t'(i + 1), 16'd2);
            w++;
            // delay slot
            instr_ram[w] = '0;
            w++;
            // zero store, only reached when the branch falls through
            instr_ram[w] = i_type(OP_SW, 5'd0, 5'd0, 16'(16'h100 + (i - 2) * 4));
            w++;
            // value store to the same slot
            instr_ram[w] = i_type(OP_SW, 5'd0, reg_idx_t'(i), 16'(16'h100 + (i - 2) * 4));
            w++;
        end

        // jr r0 then its delay slot, fetch halts after this
        instr_ram[w] = {OP_SPECIAL, 5'd0, 15'd0, FUNCT_JR};
        w++;
        instr_ram[w] = '0;
    end

    // asynchronous read
    assign instr_readdata = instr_ram[word_index[$clog2(IRAM_WORDS)-1:0]];

endmodule

// File: logic/fetch_stage.sv
module fetch_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  beq_4_pkg::branch_redirect_t redirect,
    input  beq_4_pkg::word_t            instr_readdata,
    output beq_4_pkg::word_t            instr_address,
    output beq_4_pkg::fetch_decode_t    fd,
    output logic                        active
);

    import beq_4_pkg::*;

    run_state_t state;
    word_t      pc;
    word_t      pc_next;
    logic       halt_req;

    // instruction memory is addressed straight from the pc
    assign instr_address = pc;
    assign active        = (state == RUNNING);

    // redirect applies after the delay slot now being fetched
    assign pc_next  = redirect.taken ? redirect.target : pc + 32'd4;
    // jr to address zero ends the program
    assign halt_req = redirect.taken && (redirect.target == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= RUNNING;
            pc       <= RESET_VECTOR;
            fd.valid <= 1'b0;
        end else if (state == RUNNING) begin
            fd.valid <= 1'b1;
            fd.pc    <= pc;
            fd.instr <= instr_readdata;
            pc       <= pc_next;
            // delay slot is captured in fd on this same edge
            if (halt_req) begin
                state <= HALTED;
            end
        end else begin
            // halted, pc holds and nothing new enters decode
            fd.valid <= 1'b0;
        end
    end

endmodule

// File: logic/decode_stage.sv
module decode_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  beq_4_pkg::fetch_decode_t    fd,
    input  beq_4_pkg::word_t            rs_data,
    input  beq_4_pkg::word_t            rt_data,
    output beq_4_pkg::reg_idx_t         rs_idx,
    output beq_4_pkg::reg_idx_t         rt_idx,
    output beq_4_pkg::branch_redirect_t redirect,
    output beq_4_pkg::decode_execute_t  de
);

    import beq_4_pkg::*;

    // instruction fields
    opcode_t     opcode;
    funct_t      funct;
    logic [15:0] imm;
    word_t       imm_sext;

    // decoded class
    logic is_lw;
    logic is_sw;
    logic is_beq;
    logic is_jr;

    word_t           beq_target;
    decode_execute_t de_next;

    assign opcode   = fd.instr[31:26];
    assign rs_idx   = fd.instr[25:21];
    assign rt_idx   = fd.instr[20:16];
    assign imm      = fd.instr[15:0];
    assign funct    = fd.instr[5:0];
    assign imm_sext = {{16{imm[15]}}, imm};

    // anything not listed here falls through as a nop
    assign is_lw  = (opcode == OP_LW);
    assign is_sw  = (opcode == OP_SW);
    assign is_beq = (opcode == OP_BEQ);
    assign is_jr  = (opcode == OP_SPECIAL) && (funct == FUNCT_JR);

    // offset counts words from the delay slot
    assign beq_target = fd.pc + 32'd4 + (imm_sext << 2);

    always_comb begin
        redirect.taken  = 1'b0;
        redirect.target = beq_target;
        if (fd.valid) begin
            if (is_beq && (rs_data == rt_data)) begin
                redirect.taken = 1'b1;
            end else if (is_jr) begin
                redirect.taken  = 1'b1;
                redirect.target = rs_data;
            end
        end
    end

    // only lw and sw have work left in execute
    always_comb begin
        de_next.valid      = fd.valid && (is_lw || is_sw);
        de_next.is_load    = is_lw;
        de_next.is_store   = is_sw;
        de_next.dest       = rt_idx;
        de_next.base       = rs_data;
        de_next.offset     = imm_sext;
        de_next.store_data = rt_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de.valid    <= 1'b0;
            de.is_load  <= 1'b0;
            de.is_store <= 1'b0;
        end else begin
            de <= de_next;
        end
    end

endmodule

// File: logic/register_file.sv
module register_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  beq_4_pkg::reg_idx_t   rs_idx,
    input  beq_4_pkg::reg_idx_t   rt_idx,
    input  beq_4_pkg::reg_write_t wb,
    output beq_4_pkg::word_t      rs_data,
    output beq_4_pkg::word_t      rt_data
);

    import beq_4_pkg::*;

    // entry 0 is cleared by reset and never written
    word_t regs [0:31];

    // write-back from execute lands at the end of the cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (wb.en && (wb.idx != '0)) begin
            regs[wb.idx] <= wb.data;
        end
    end

    // bypass lets a beq right after lw see the loaded value
    assign rs_data = (wb.en && (wb.idx == rs_idx) && (rs_idx != '0)) ? wb.data
                                                                     : regs[rs_idx];
    assign rt_data = (wb.en && (wb.idx == rt_idx) && (rt_idx != '0)) ? wb.data
                                                                     : regs[rt_idx];

endmodule

// File: logic/execute_stage.sv
module execute_stage (
    input  beq_4_pkg::decode_execute_t de,
    input  beq_4_pkg::word_t           data_readdata,
    output logic                       data_read,
    output logic                       data_write,
    output beq_4_pkg::word_t           data_address,
    output beq_4_pkg::word_t           data_writedata,
    output beq_4_pkg::reg_write_t      wb
);

    import beq_4_pkg::*;

    logic do_load;
    logic do_store;

    // strobes only for a valid memory op
    assign do_load  = de.valid && de.is_load;
    assign do_store = de.valid && de.is_store;

    assign data_read  = do_load;
    assign data_write = do_store;

    // base plus sign-extended offset
    assign data_address = de.base + de.offset;

    // store data was read in decode
    assign data_writedata = de.store_data;

    // load data comes back in the same cycle and goes straight to the register file
    always_comb begin
        wb.en   = do_load;
        wb.idx  = de.dest;
        wb.data = data_readdata;
    end

endmodule

// File: logic/beq_4_cpu_top.sv
module beq_4_cpu_top (
    input  logic             clk,
    input  logic             rst_n,
    output logic             active,
    output logic             data_read,
    output logic             data_write,
    output beq_4_pkg::word_t data_address,
    output beq_4_pkg::word_t data_writedata,
    input  beq_4_pkg::word_t data_readdata
);

    import beq_4_pkg::*;

    // instruction bus
    word_t instr_address;
    word_t instr_readdata;

    // pipeline registers and feedback paths
    fetch_decode_t    fd;
    decode_execute_t  de;
    branch_redirect_t redirect;
    reg_write_t       wb;

    // register file read ports
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;

    beq_4_iram u_iram (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

    fetch_stage u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect       (redirect),
        .instr_readdata (instr_readdata),
        .instr_address  (instr_address),
        .fd             (fd),
        .active         (active)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .fd       (fd),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .redirect (redirect),
        .de       (de)
    );

    register_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .wb      (wb),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    execute_stage u_execute (
        .de             (de),
        .data_readdata  (data_readdata),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .wb             (wb)
    );

endmodule

// File: testbench/beq_4_props.sv
module beq_4_props (
    input logic             clk,
    input logic             rst_n,
    input logic             active,
    input logic             data_read,
    input logic             data_write,
    input beq_4_pkg::word_t data_address
);

    // one access kind per cycle
    a_single_strobe: assert property (@(posedge clk) !(data_read && data_write))
        else $error("data_read and data_write asserted in the same cycle");

    // execute register is cleared while reset is held
    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !(data_read || data_write))
        else $error("data bus strobe while rst_n is low");

    // lw and sw move whole words
    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (data_read || data_write) |-> (data_address[1:0] == 2'b00))
        else $error("unaligned data_address %h", data_address);

    // halt holds until the next reset
    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        !active |=> !active)
        else $error("active rose again without a reset");

endmodule

// File: testbench/beq_4_tb.sv
module beq_4_tb;

    import beq_4_pkg::*;

    logic  clk;
    logic  rst_n;
    logic  active;
    logic  data_read;
    logic  data_write;
    word_t data_address;
    word_t data_writedata;
    word_t data_readdata;

    // data memory, reloaded from next_image while reset is held
    word_t data_mem [0:255];
    word_t next_image [0:255];
    // values for r2 to r31, entry k ends up in register k+2
    word_t load_vals [0:29];
    // expected stores in bus order
    word_t exp_addr [0:57];
    word_t exp_data [0:57];
    int    exp_count = 0;

    int load_count = 0;
    int store_count = 0;
    int after_reset = 0;
    int check_count = 0;
    int check_errors = 0;
    int run_errors = 0;
    int run_count = 0;
    int seed = 27;

    beq_4_cpu_top u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .active         (active),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    bind beq_4_cpu_top beq_4_props u_props (
        .clk          (clk),
        .rst_n        (rst_n),
        .active       (active),
        .data_read    (data_read),
        .data_write   (data_write),
        .data_address (data_address)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // read data answers in the same cycle
    assign data_readdata = data_mem[data_address[9:2]];

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int a = 0; a < 256; a++) begin
                data_mem[a] <= next_image[a];
            end
        end else if (data_write) begin
            data_mem[data_address[9:2]] <= data_writedata;
        end
    end

    // store list for the loaded values, zero store only where beq falls through
    function automatic int expected_stores();
        int n;
        int k;
        word_t slot;
        n = 0;
        for (k = 0; k < 29; k++) begin
            slot = 32'h100 + word_t'(4 * k);
            if (load_vals[k] != load_vals[k + 1]) begin
                exp_addr[n] = slot;
                exp_data[n] = 32'd0;
                n++;
            end
            exp_addr[n] = slot;
            exp_data[n] = load_vals[k];
            n++;
        end
        return n;
    endfunction

    task automatic flag_value(input string name, input word_t got, input word_t want);
        $display("ERROR t=%0t %s got %h expected %h", $time, name, got, want);
        check_errors++;
    endtask

    // compares every strobe with the expected bus traffic
    always @(posedge clk) begin
        if (!rst_n) begin
            after_reset <= 0;
            load_count  <= 0;
            store_count <= 0;
            if (data_read || data_write) begin
                flag_value("{data_read,data_write}", word_t'({data_read, data_write}), 32'd0);
            end
        end else begin
            after_reset <= after_reset + 1;
            // first cycle after release, execute still holds its reset value
            if (after_reset == 0 && (data_read || data_write || !active)) begin
                flag_value("{active,data_read,data_write}",
                           word_t'({active, data_read, data_write}), 32'd4);
            end
            if (!active && (data_read || data_write)) begin
                $display("data bus strobe after the processor halted at t=%0t", $time);
                check_errors++;
            end
            // loads walk the data words in rising order
            if (data_read) begin
                check_count++;
                if (data_address !== word_t'(4 * load_count)) begin
                    flag_value("data_address", data_address, word_t'(4 * load_count));
                end
                load_count <= load_count + 1;
            end
            if (data_write) begin
                check_count++;
                if (store_count >= exp_count) begin
                    $display("store beyond the expected list at t=%0t", $time);
                    check_errors++;
                end else begin
                    if (data_address !== exp_addr[store_count]) begin
                        flag_value("data_address", data_address, exp_addr[store_count]);
                    end
                    if (data_writedata !== exp_data[store_count]) begin
                        flag_value("data_writedata", data_writedata, exp_data[store_count]);
                    end
                end
                store_count <= store_count + 1;
            end
        end
    end

    // kind 0 takes every beq, kind 1 none, other kinds mix at random
    task automatic run_program(input int kind, input string label);
        int k;
        int cycles;
        int errors_before;
        errors_before = check_errors + run_errors;
        for (k = 0; k < 30; k++) begin
            if (kind == 0) begin
                load_vals[k] = 32'h5A5A_0F0F;
            end else if (kind == 1) begin
                load_vals[k] = 32'h0001_0000 + word_t'(3 * k + 1);
            end else if (k > 0 && (($random(seed) & 1) != 0)) begin
                load_vals[k] = load_vals[k - 1];
            end else begin
                load_vals[k] = $random(seed);
            end
        end
        // words outside the load area carry their byte address
        for (k = 0; k < 256; k++) begin
            next_image[k] = (k < 30) ? load_vals[k] : (32'hA500_0000 | word_t'(k << 2));
        end
        exp_count = expected_stores();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // reset again mid-program with all loads done and a sw waiting in fetch
        repeat (33) @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        @(posedge clk);
        while (active && cycles < 300) begin
            @(posedge clk);
            cycles++;
        end
        if (active) begin
            $display("%s run did not halt within 300 cycles", label);
            run_errors++;
        end
        // quiet window after halt, watched by the compare process
        repeat (20) @(posedge clk);
        if (load_count != 30) begin
            $display("ERROR t=%0t load_count got %0d expected 30", $time, load_count);
            run_errors++;
        end
        if (store_count != exp_count) begin
            $display("ERROR t=%0t store_count got %0d expected %0d",
                     $time, store_count, exp_count);
            run_errors++;
        end
        run_count++;
        $display("run %0d (%s): %0d loads, %0d stores, %s", run_count, label, load_count,
                 store_count, (check_errors + run_errors == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rst_n = 1'b0;
        run_program(0, "all equal");
        run_program(1, "all different");
        repeat (4) run_program(2, "random");
        $display("runs %0d, checks %0d, errors %0d", run_count, check_count + 2 * run_count,
                 check_errors + run_errors);
        if (check_errors + run_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // six runs of at most 300 cycles each
    initial begin
        #(6 * 300 * 100);
        $display("simulation timed out before all runs finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: beq_4.f
logic/beq_4_pkg.sv
logic/beq_4_iram.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/register_file.sv
logic/execute_stage.sv
logic/beq_4_cpu_top.sv
testbench/beq_4_props.sv
testbench/beq_4_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the beq_4 testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module beq_4_tb -f beq_4.f -o beq_4_sim

# exit status of the pipeline is tee's, the log decides
./obj_dir/beq_4_sim 2>&1 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
